// ==== src/core_pkg.sv ====
/* Shared types, opcodes, ALU and forwarding codes, reset values
   and FSM state enums for the pipelined core */
package core_pkg;

	typedef logic [31:0] word_t;     // Data, address or instruction word
	typedef logic [4:0]  reg_addr_t; // Register index
	typedef logic [2:0]  alu_op_t;   // ALU operation code
	typedef logic [1:0]  fwd_sel_t;  // Operand source select

	// ALU operations
	localparam alu_op_t ALU_ADD    = 3'd0;
	localparam alu_op_t ALU_SUB    = 3'd1;
	localparam alu_op_t ALU_AND    = 3'd2;
	localparam alu_op_t ALU_OR     = 3'd3;
	localparam alu_op_t ALU_XOR    = 3'd4;
	localparam alu_op_t ALU_SLT    = 3'd5;
	localparam alu_op_t ALU_PASS_B = 3'd6; // LUI immediate passes through

	localparam fwd_sel_t FWD_NONE = 2'd0; // Value from register file
	localparam fwd_sel_t FWD_MEM  = 2'd1;
	localparam fwd_sel_t FWD_WB   = 2'd2;

	// RV32I major opcodes
	localparam logic [6:0] OP_REG   = 7'b0110011;
	localparam logic [6:0] OP_IMM   = 7'b0010011;
	localparam logic [6:0] OP_LUI   = 7'b0110111;
	localparam logic [6:0] OP_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;

	localparam word_t NOP_INSTR = 32'h0000_0013; // ADDI x0,x0,0
	localparam word_t RESET_PC  = 32'h0000_0000;

	typedef enum logic       {F_IDLE, F_WAIT} fetch_state_e;
	typedef enum logic [1:0] {A_IDLE, A_BUSY_I, A_BUSY_D} arb_state_e;

endpackage

// ==== src/mem_bus_if.sv ====
/* Memory request and response bundle for one requester */
`timescale 1ns/1ps

interface mem_bus_if import core_pkg::*; ();

	logic  req_valid; // Request held until accepted
	logic  req_ready;
	word_t addr;
	logic  we;        // High for a write
	word_t wdata;
	logic  rsp_valid; // One pulse per accepted request, writes too
	word_t rdata;

	modport requester (
		output req_valid, addr, we, wdata,
		input  req_ready, rsp_valid, rdata
	);

	modport arbiter (
		input  req_valid, addr, we, wdata,
		output req_ready, rsp_valid, rdata
	);

endinterface

// ==== src/fetch_unit.sv ====
/* Instruction fetch: PC, instruction bus requests and a one-entry buffer */
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
	input  logic                clk,
	input  logic                nrst,
	input  logic                take,        // Decode consumes the buffer
	mem_bus_if.requester        ibus,
	output logic                fetch_valid,
	output word_t               fetch_instr
);

	fetch_state_e state;
	word_t        pc;
	logic         buf_valid;
	word_t        buf_instr; // Payload only

	// Buffer stays empty once freed, so the request holds until accepted
	assign ibus.req_valid = nrst && (state == F_IDLE) && (!buf_valid || take); // Quiet in reset
	assign ibus.addr      = pc;
	assign ibus.we        = 1'b0; // Fetch never writes
	assign ibus.wdata     = '0;

	assign fetch_valid = buf_valid;
	assign fetch_instr = buf_instr;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state     <= F_IDLE;
			pc        <= RESET_PC;
			buf_valid <= 1'b0;
		end else begin
			case (state)
				F_IDLE: if (ibus.req_valid && ibus.req_ready) begin
					state <= F_WAIT;
					pc    <= pc + 32'd4; // Next sequential word
				end
				F_WAIT: if (ibus.rsp_valid) state <= F_IDLE;
				default: state <= F_IDLE;
			endcase
			if (ibus.rsp_valid) buf_valid <= 1'b1; // Buffer is empty here
			else if (take)      buf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ibus.rsp_valid) buf_instr <= ibus.rdata;
	end

endmodule

// ==== src/decoder.sv ====
/* Instruction decoder: fields, immediates and stage controls */
`timescale 1ns/1ps

module decoder import core_pkg::*; (
	input  word_t     instr,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	output reg_addr_t rd,
	output word_t     imm,
	output alu_op_t   alu_op,
	output logic      use_imm,  // Operand B from immediate
	output logic      rf_we,
	output logic      is_load,
	output logic      is_store
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       valid;          // Supported encoding
	logic       use_rs1, use_rs2, use_rd;
	logic       ld, st;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		valid   = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_rd  = 1'b0;
		ld      = 1'b0;
		st      = 1'b0;
		use_imm = 1'b0;
		alu_op  = ALU_ADD;
		imm     = '0;
		case (opcode)
			OP_REG: begin
				{valid, use_rs1, use_rs2, use_rd} = 4'b1111;
				case ({funct7, funct3})
					{7'h00, 3'b000}: alu_op = ALU_ADD;
					{7'h20, 3'b000}: alu_op = ALU_SUB;
					{7'h00, 3'b111}: alu_op = ALU_AND;
					{7'h00, 3'b110}: alu_op = ALU_OR;
					{7'h00, 3'b100}: alu_op = ALU_XOR;
					{7'h00, 3'b010}: alu_op = ALU_SLT;
					default:         valid  = 1'b0;
				endcase
			end
			OP_IMM: begin
				{valid, use_rs1, use_rd, use_imm} = 4'b1111;
				imm = {{20{instr[31]}}, instr[31:20]}; // I-type
				case (funct3)
					3'b000:  alu_op = ALU_ADD;
					3'b111:  alu_op = ALU_AND;
					3'b110:  alu_op = ALU_OR;
					3'b100:  alu_op = ALU_XOR;
					default: valid  = 1'b0; // SLTI and shifts are NOPs
				endcase
			end
			OP_LUI: begin
				{valid, use_rd, use_imm} = 3'b111;
				imm    = {instr[31:12], 12'h000}; // U-type
				alu_op = ALU_PASS_B;
			end
			OP_LOAD: begin
				{use_rs1, use_rd, use_imm, ld} = 4'b1111;
				valid = (funct3 == 3'b010); // LW only
				imm   = {{20{instr[31]}}, instr[31:20]};
			end
			OP_STORE: begin
				{use_rs1, use_rs2, use_imm, st} = 4'b1111;
				valid = (funct3 == 3'b010); // SW only
				imm   = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // S-type
			end
			default: valid = 1'b0;
		endcase
	end

	// Unused indices forced to x0 so forwarding never hits them
	assign rs1      = (valid && use_rs1) ? instr[19:15] : '0;
	assign rs2      = (valid && use_rs2) ? instr[24:20] : '0;
	assign rd       = (valid && use_rd)  ? instr[11:7]  : '0;
	assign rf_we    = valid && use_rd && (instr[11:7] != '0);
	assign is_load  = valid && ld;
	assign is_store = valid && st;

endmodule

// ==== src/reg_file.sv ====
/* 32 x 32-bit register file, two read ports with write-through */
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
	input  logic      clk,
	input  logic      nrst,
	input  reg_addr_t rd_addr1,
	input  reg_addr_t rd_addr2,
	input  reg_addr_t wr_addr,
	input  logic      wr_en,
	input  word_t     wr_data,
	output word_t     rd_data1,
	output word_t     rd_data2
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (!nrst) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data; // x0 never written
		end
	end

	// x0 reads zero, a same-cycle write is bypassed
	assign rd_data1 = (rd_addr1 == '0) ? '0 :
		(wr_en && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
	assign rd_data2 = (rd_addr2 == '0) ? '0 :
		(wr_en && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

endmodule

// ==== src/forward_unit.sv ====
/* Operand forwarding selects and load-use hazard detection */
`timescale 1ns/1ps

module forward_unit import core_pkg::*; (
	input  reg_addr_t ex_rs1, ex_rs2,
	input  reg_addr_t mem_rd, wb_rd,
	input  reg_addr_t dec_rs1, dec_rs2,
	input  reg_addr_t ex_rd,
	input  logic      mem_we, wb_we,
	input  logic      ex_is_load,
	output fwd_sel_t  fwd_a, fwd_b,
	output logic      load_stall
);

	// Youngest producer wins, x0 never forwarded
	function automatic fwd_sel_t pick(reg_addr_t rs, reg_addr_t mrd, logic mwe,
			reg_addr_t wrd, logic wwe);
		if (rs == '0)               return FWD_NONE;
		if (mwe && mrd == rs)       return FWD_MEM;
		if (wwe && wrd == rs)       return FWD_WB;
		return FWD_NONE;
	endfunction

	assign fwd_a = pick(ex_rs1, mem_rd, mem_we, wb_rd, wb_we);
	assign fwd_b = pick(ex_rs2, mem_rd, mem_we, wb_rd, wb_we);

	assign load_stall = ex_is_load && (ex_rd != '0) &&
		((ex_rd == dec_rs1) || (ex_rd == dec_rs2)); // Load result not ready yet

endmodule

// ==== src/alu.sv ====
/* Combinational ALU for the supported integer subset */
`timescale 1ns/1ps

module alu import core_pkg::*; (
	input  word_t   a,
	input  word_t   b,
	input  alu_op_t op,
	output word_t   result
);

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_AND:    result = a & b;
			ALU_OR:     result = a | b;
			ALU_XOR:    result = a ^ b;
			ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)}; // Signed compare
			ALU_PASS_B: result = b;  // LUI
			default:    result = '0;
		endcase
	end

endmodule

// ==== src/mem_arbiter.sv ====
/* Two-requester arbiter onto the external memory port, data first,
   one transaction in flight */
`timescale 1ns/1ps

module mem_arbiter import core_pkg::*; (
	input  logic       clk,
	input  logic       nrst,
	mem_bus_if.arbiter ibus,
	mem_bus_if.arbiter dbus,
	output logic       mem_valid,
	output logic       mem_we,
	input  logic       mem_ready,
	input  logic       mem_rvalid,
	output word_t      mem_addr,
	output word_t      mem_wdata,
	input  word_t      mem_rdata
);

	arb_state_e state;
	logic       lock_i;  // Waiting ibus request keeps the port
	logic       gnt_d;

	assign gnt_d     = dbus.req_valid && !lock_i;
	assign mem_valid = (state == A_IDLE) && (dbus.req_valid || ibus.req_valid);
	assign mem_addr  = gnt_d ? dbus.addr  : ibus.addr;
	assign mem_we    = gnt_d ? dbus.we    : ibus.we;
	assign mem_wdata = gnt_d ? dbus.wdata : ibus.wdata;

	assign dbus.req_ready = (state == A_IDLE) && gnt_d && mem_ready;
	assign ibus.req_ready = (state == A_IDLE) && !gnt_d && mem_ready;

	// Response goes back to the owner only
	assign dbus.rsp_valid = mem_rvalid && (state == A_BUSY_D);
	assign ibus.rsp_valid = mem_rvalid && (state == A_BUSY_I);
	assign dbus.rdata     = mem_rdata;
	assign ibus.rdata     = mem_rdata;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state  <= A_IDLE;
			lock_i <= 1'b0;
		end else begin
			lock_i <= mem_valid && !mem_ready && !gnt_d;
			case (state)
				A_IDLE:   if (mem_valid && mem_ready) state <= gnt_d ? A_BUSY_D : A_BUSY_I;
				A_BUSY_I,
				A_BUSY_D: if (mem_rvalid) state <= A_IDLE;
				default:  state <= A_IDLE;
			endcase
		end
	end

endmodule

// ==== src/riscv_core.sv ====
/* Five-stage RV32I subset core: stage registers, operand muxes,
   pipeline enables and the shared memory port */
`timescale 1ns/1ps

module riscv_core import core_pkg::*; (
	input  logic  clk,
	input  logic  nrst,        // Synchronous, active low
	output logic  mem_valid,
	input  logic  mem_ready,
	output word_t mem_addr,
	output logic  mem_we,
	output word_t mem_wdata,
	input  logic  mem_rvalid,
	input  word_t mem_rdata
);

	mem_bus_if ibus ();
	mem_bus_if dbus ();

	logic      pipe_en, take, load_stall;
	logic      fetch_valid;
	word_t     fetch_instr, dec_instr;
	reg_addr_t d_rs1, d_rs2, d_rd;
	word_t     d_imm, rf_rd1, rf_rd2;
	alu_op_t   d_alu_op, ex_alu_op;
	logic      d_use_imm, d_rf_we, d_is_load, d_is_store;
	reg_addr_t ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;
	word_t     ex_op1, ex_op2, ex_imm;
	logic      ex_use_imm, ex_rf_we, ex_is_load, ex_is_store;
	fwd_sel_t  fwd_a, fwd_b;
	word_t     opa, opb, alu_res;
	word_t     mem_alu, mem_sdata, wb_data;
	logic      mem_rf_we, mem_is_load, mem_is_store, wb_rf_we;
	logic      mem_access, d_sent;

	fetch_unit u_fetch (.clk(clk), .nrst(nrst), .take(take), .ibus(ibus),
		.fetch_valid(fetch_valid), .fetch_instr(fetch_instr));

	////////////////////
	// Decode
	////////////////////
	always_ff @(posedge clk) begin
		if (!nrst)     dec_instr <= NOP_INSTR;
		else if (take) dec_instr <= fetch_valid ? fetch_instr : NOP_INSTR; // Gap becomes NOP
	end

	decoder u_dec (.instr(dec_instr), .rs1(d_rs1), .rs2(d_rs2), .rd(d_rd), .imm(d_imm),
		.alu_op(d_alu_op), .use_imm(d_use_imm), .rf_we(d_rf_we),
		.is_load(d_is_load), .is_store(d_is_store));

	reg_file u_rf (.clk(clk), .nrst(nrst), .rd_addr1(d_rs1), .rd_addr2(d_rs2),
		.wr_addr(wb_rd), .wr_en(wb_rf_we), .wr_data(wb_data),
		.rd_data1(rf_rd1), .rd_data2(rf_rd2));

	always_ff @(posedge clk) begin
		if (!nrst) begin
			{ex_rf_we, ex_is_load, ex_is_store} <= '0;
			{ex_rd, ex_rs1, ex_rs2} <= '0;
		end else if (pipe_en) begin
			if (load_stall) begin // Bubble into execute
				{ex_rf_we, ex_is_load, ex_is_store} <= '0;
				{ex_rd, ex_rs1, ex_rs2} <= '0;
			end else begin
				{ex_rf_we, ex_is_load, ex_is_store} <= {d_rf_we, d_is_load, d_is_store};
				{ex_rd, ex_rs1, ex_rs2} <= {d_rd, d_rs1, d_rs2};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pipe_en) begin
			ex_op1     <= rf_rd1;
			ex_op2     <= rf_rd2;
			ex_imm     <= d_imm;
			ex_alu_op  <= d_alu_op;
			ex_use_imm <= d_use_imm;
		end
	end

	////////////////////
	// Execute
	////////////////////
	forward_unit u_fwd (.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .mem_rd(mem_rd), .wb_rd(wb_rd),
		.dec_rs1(d_rs1), .dec_rs2(d_rs2), .ex_rd(ex_rd), .mem_we(mem_rf_we),
		.wb_we(wb_rf_we), .ex_is_load(ex_is_load), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.load_stall(load_stall));

	function automatic word_t fwd_val(fwd_sel_t sel, word_t rf, word_t m, word_t w);
		case (sel)
			FWD_MEM: return m;
			FWD_WB:  return w;
			default: return rf;
		endcase
	endfunction

	assign opa = fwd_val(fwd_a, ex_op1, mem_alu, wb_data);
	assign opb = fwd_val(fwd_b, ex_op2, mem_alu, wb_data); // Also the store data

	alu u_alu (.a(opa), .b(ex_use_imm ? ex_imm : opb), .op(ex_alu_op), .result(alu_res));

	always_ff @(posedge clk) begin
		if (!nrst) begin
			{mem_rf_we, mem_is_load, mem_is_store} <= '0;
			mem_rd <= '0;
		end else if (pipe_en) begin
			{mem_rf_we, mem_is_load, mem_is_store} <= {ex_rf_we, ex_is_load, ex_is_store};
			mem_rd <= ex_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (pipe_en) begin
			mem_alu   <= alu_res; // Address for loads and stores
			mem_sdata <= opb;
		end
	end

	////////////////////
	// Memory and writeback
	////////////////////
	assign mem_access     = mem_is_load || mem_is_store;
	assign dbus.req_valid = mem_access && !d_sent;
	assign dbus.addr      = mem_alu;
	assign dbus.we        = mem_is_store;
	assign dbus.wdata     = mem_sdata;

	assign pipe_en = !mem_access || dbus.rsp_valid; // Response cycle advances all
	assign take    = pipe_en && !load_stall;

	always_ff @(posedge clk) begin
		if (!nrst)                                  d_sent <= 1'b0;
		else if (dbus.rsp_valid)                    d_sent <= 1'b0;
		else if (dbus.req_valid && dbus.req_ready) d_sent <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			wb_rf_we <= 1'b0;
			wb_rd    <= '0;
		end else if (pipe_en) begin
			wb_rf_we <= mem_rf_we;
			wb_rd    <= mem_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (pipe_en) wb_data <= mem_is_load ? dbus.rdata : mem_alu;
	end

	mem_arbiter u_arb (.clk(clk), .nrst(nrst), .ibus(ibus), .dbus(dbus),
		.mem_valid(mem_valid), .mem_we(mem_we), .mem_ready(mem_ready),
		.mem_rvalid(mem_rvalid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata));

endmodule

// ==== testbench/riscv_core_asserts.sv ====
/* Concurrent checks on the external memory port of the core */
`timescale 1ns/1ps

module riscv_core_asserts import core_pkg::*; (
	input logic  clk,
	input logic  nrst,
	input logic  mem_valid,
	input logic  mem_ready,
	input word_t mem_addr,
	input logic  mem_we,
	input word_t mem_wdata,
	input logic  mem_rvalid
);

	int unsigned fail_count = 0; // Read by the testbench monitor
	logic        armed = 1'b0;   // Low on the first edge, before the FSMs see reset
	logic        outstanding;    // Accepted request still waiting for its response

	always @(posedge clk) begin
		armed <= 1'b1;
		if (!nrst)                       outstanding <= 1'b0;
		else if (mem_valid && mem_ready) outstanding <= 1'b1; // New request wins over a response
		else if (mem_rvalid)             outstanding <= 1'b0;
	end

	a_reset_idle: assert property (@(posedge clk) armed && !nrst |-> !mem_valid)
		else begin
			fail_count++;
			$error("mem_valid high during reset");
		end

	// Held request keeps address, direction and data
	a_req_stable: assert property (@(posedge clk) disable iff (!nrst)
		mem_valid && !mem_ready |=>
			mem_valid && $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))
		else begin
			fail_count++;
			$error("request changed or dropped before acceptance");
		end

	a_one_outstanding: assert property (@(posedge clk) disable iff (!nrst)
		outstanding |-> !(mem_valid && mem_ready))
		else begin
			fail_count++;
			$error("request accepted while a response is outstanding");
		end

endmodule

// ==== testbench/tb_riscv_core.sv ====
/* Testbench for the pipelined core: random program, memory model with random
   latency, in-order reference model and store checker */
`timescale 1ns/1ps

module tb_riscv_core import core_pkg::*; ();

	logic  clk;
	logic  nrst;
	logic  mem_valid, mem_ready, mem_we, mem_rvalid;
	word_t mem_addr, mem_wdata, mem_rdata;
	logic  last_fetch;       // Last word of the code region was fetched

	word_t mem [1024];       // Code in words 0 to 255 and data from 0x400
	word_t model_mem [1024]; // Reference copy of the data region
	word_t xr [8];           // Reference registers x0 to x7
	word_t exp_addr [$];     // Stores in program order
	word_t exp_data [$];

	riscv_core dut (.clk(clk), .nrst(nrst), .mem_valid(mem_valid), .mem_ready(mem_ready),
		.mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata));

	bind riscv_core riscv_core_asserts u_asserts (.clk(clk), .nrst(nrst),
		.mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
		.mem_we(mem_we), .mem_wdata(mem_wdata), .mem_rvalid(mem_rvalid));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	task automatic fail_run(string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_equal(string name, word_t got, word_t exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	// Mixes every address bit into the initial data
	function automatic word_t fill_word(word_t addr);
		return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, logic [2:0] rd,
			logic [2:0] rs1, logic [2:0] rs2);
		return {f7, 2'b00, rs2, 2'b00, rs1, f3, 2'b00, rd, OP_REG};
	endfunction

	function automatic word_t enc_i(logic [6:0] op, logic [2:0] f3, logic [2:0] rd,
			logic [2:0] rs1, logic [11:0] imm);
		return {imm, 2'b00, rs1, f3, 2'b00, rd, op};
	endfunction

	////////////////////
	// Program and reference model
	////////////////////
	task automatic build_program();
		int          kind;
		word_t       rnd, ins, a, b, sx, res;
		logic [2:0]  rd, rs1, rs2;
		logic [11:0] imm, off;
		for (int i = 0; i < 1024; i++) begin
			mem[i[9:0]]       = (i < 256) ? NOP_INSTR : fill_word({i[29:0], 2'b00});
			model_mem[i[9:0]] = mem[i[9:0]];
		end
		for (int r = 0; r < 8; r++) xr[r[2:0]] = '0;
		for (int i = 0; i < 200; i++) begin
			kind = $urandom_range(0, 13); // 12 and 13 are both SW
			rnd  = $urandom();
			rd   = rnd[2:0];
			rs1  = rnd[5:3];
			rs2  = rnd[8:6];
			imm  = rnd[20:9];
			off  = {2'b01, rnd[29:22], 2'b00}; // 0x400 to 0x7FC with base x0
			a    = xr[rs1];
			b    = xr[rs2];
			sx   = {{20{imm[11]}}, imm};
			res  = '0;
			case (kind)
				0:  begin ins = enc_r(7'h00, 3'b000, rd, rs1, rs2); res = a + b; end
				1:  begin ins = enc_r(7'h20, 3'b000, rd, rs1, rs2); res = a - b; end
				2:  begin ins = enc_r(7'h00, 3'b111, rd, rs1, rs2); res = a & b; end
				3:  begin ins = enc_r(7'h00, 3'b110, rd, rs1, rs2); res = a | b; end
				4:  begin ins = enc_r(7'h00, 3'b100, rd, rs1, rs2); res = a ^ b; end
				5:  begin
					ins = enc_r(7'h00, 3'b010, rd, rs1, rs2);
					res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // Signed compare
				end
				6:  begin ins = enc_i(OP_IMM, 3'b000, rd, rs1, imm); res = a + sx; end
				7:  begin ins = enc_i(OP_IMM, 3'b111, rd, rs1, imm); res = a & sx; end
				8:  begin ins = enc_i(OP_IMM, 3'b110, rd, rs1, imm); res = a | sx; end
				9:  begin ins = enc_i(OP_IMM, 3'b100, rd, rs1, imm); res = a ^ sx; end
				10: begin ins = {rnd[31:12], 2'b00, rd, OP_LUI}; res = {rnd[31:12], 12'h000}; end
				11: begin
					ins = enc_i(OP_LOAD, 3'b010, rd, 3'b000, off);
					res = model_mem[off[11:2]]; // Most recent store or the fill
				end
				default: begin
					ins = {off[11:5], 2'b00, rs2, 5'd0, 3'b010, off[4:0], OP_STORE};
					model_mem[off[11:2]] = b;
					exp_addr.push_back({20'h0, off});
					exp_data.push_back(b);
				end
			endcase
			mem[i[9:0]] = ins;
			if (kind < 12 && rd != 3'd0) xr[rd] = res;
		end
	endtask

	////////////////////
	// Memory model
	////////////////////
	task automatic run_memory();
		int    delay;
		logic  busy;
		word_t rsp;
		busy  = 1'b0;
		delay = 0;
		rsp   = '0;
		forever begin
			@(negedge clk);
			mem_rvalid = 1'b0;
			if (busy) begin
				if (delay == 0) begin
					mem_rvalid = 1'b1; // Seen at the next rising edge
					mem_rdata  = rsp;
					busy       = 1'b0;
				end else begin
					delay--;
				end
			end
			mem_ready = ($urandom_range(0, 2) != 0);
			#1; // Request settled and accepted at the next rising edge
			if (mem_valid && mem_ready) begin
				if (mem_we) begin
					if (exp_addr.size() == 0)
						fail_run("Store request seen after the last store of the program");
					check_equal("mem_addr", mem_addr, exp_addr.pop_front());
					check_equal("mem_wdata", mem_wdata, exp_data.pop_front());
					mem[mem_addr[11:2]] = mem_wdata;
				end
				if (!mem_we && mem_addr == 32'h0000_03FC)
					last_fetch = 1'b1; // Word 255 ends the code region
				rsp   = mem[mem_addr[11:2]];
				busy  = 1'b1;
				delay = $urandom_range(0, 3); // 1 to 4 cycles
			end
		end
	endtask

	always @(negedge clk) begin
		if (dut.u_asserts.fail_count != 0) fail_run("Assertion failure on the memory port");
	end

	initial begin
		int cycles;
		nrst       = 1'b0;
		mem_ready  = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata  = '0;
		last_fetch = 1'b0;
		void'($urandom(32'h2257_4976));
		build_program();
		repeat (16) @(negedge clk);
		nrst = 1'b1;
		fork
			run_memory();
		join_none
		cycles = 0;
		while (exp_addr.size() != 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > 20000) fail_run("Timed out waiting for the remaining stores");
		end
		cycles = 0;
		while (!last_fetch) begin // Trailing instructions must not write
			@(negedge clk);
			cycles++;
			if (cycles > 4000)
				fail_run("Timed out waiting for the last code word to be fetched");
		end
		if (dut.u_asserts.fail_count != 0) begin
			fail_run("Assertion failure on the memory port");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

// ==== project.f ====
src/core_pkg.sv
src/mem_bus_if.sv
src/fetch_unit.sv
src/decoder.sv
src/reg_file.sv
src/forward_unit.sv
src/alu.sv
src/mem_arbiter.sv
src/riscv_core.sv
testbench/riscv_core_asserts.sv
testbench/tb_riscv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= === FAIL ===
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -- "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q -- "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
